//--- design/fm_consts.svh
`ifndef FM_CONSTS_SVH
`define FM_CONSTS_SVH

// Channel count and datapath widths
`define FM_NUM_CH       3
`define FM_PHASE_W      20
`define FM_OUT_W        12

// Timer B advances once per this many sample ticks
`define FM_TB_PRESCALE  16

// Timer registers
`define FM_REG_TA_HI    8'h24
`define FM_REG_TA_LO    8'h25
`define FM_REG_TB       8'h26
`define FM_REG_TCTRL    8'h27

// PCM replaces channel 2 when enabled (bit 7)
`define FM_REG_PCM      8'h2A
`define FM_REG_PCM_EN   8'h2B

// Per-channel registers, base plus channel number
`define FM_REG_FNUM_LO  8'hA0
`define FM_REG_FNUM_HI  8'hA4
`define FM_REG_PAN      8'hB4

`endif

//--- design/fm_pkg.sv
`include "fm_consts.svh"

package fm_pkg;

	typedef logic [10:0]               fnum_t;
	typedef logic [2:0]                block_t;
	typedef logic [`FM_PHASE_W-1:0]    phase_t;
	typedef logic signed [`FM_OUT_W-1:0] sample_t;
	// Bit 1 is left, bit 0 is right
	typedef logic [1:0]                pan_t;
	typedef logic [7:0]                pcm_t;
	typedef logic [9:0]                ta_value_t;
	typedef logic [7:0]                tb_value_t;

	// Time slots of one output round
	typedef enum logic [1:0] {
		SLOT_CH0,
		SLOT_CH1,
		SLOT_CH2,
		SLOT_OUT
	} slot_e;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic       adr;
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		fnum_t  fnum;
		block_t block;
		pan_t   pan;
	} ch_cfg_t;

	typedef struct packed {
		ta_value_t value_a;
		tb_value_t value_b;
		logic      load_a;
		logic      load_b;
		logic      irq_en_a;
		logic      irq_en_b;
		logic      clr_a;
		logic      clr_b;
	} timer_cfg_t;

	typedef struct packed {
		logic flag_a;
		logic flag_b;
	} timer_flags_t;

endpackage

//--- design/fm_regs.sv
`timescale 1ns/1ps
`include "fm_consts.svh"

module fm_regs (
	input  logic                                clk_int,
	input  logic                                reset,
	input  fm_pkg::wb_req_t                     wb_req,
	input  fm_pkg::timer_flags_t                flags,
	output fm_pkg::wb_rsp_t                     wb_rsp,
	output fm_pkg::timer_cfg_t                  timer_cfg,
	output fm_pkg::ch_cfg_t [`FM_NUM_CH-1:0]    ch_cfg,
	output fm_pkg::pcm_t                        pcm,
	output logic                                pcm_en
);

	logic              ack;
	logic [7:0]        rd_dat;
	logic              req;
	logic              wr_addr;
	logic              wr_data;
	logic [7:0]        reg_num;

	logic [7:0]        ta_hi;
	logic [1:0]        ta_lo;
	fm_pkg::tb_value_t tb_val;
	logic [3:0]        tctrl;
	logic              clr_a;
	logic              clr_b;

	// A new access only while ack is still low
	assign req     = wb_req.cyc & wb_req.stb & ~ack;
	assign wr_addr = req & wb_req.we & ~wb_req.adr;
	assign wr_data = req & wb_req.we & wb_req.adr;

	// Bus handshake and status read
	always_ff @(posedge clk_int) begin
		if (reset) begin
			ack    <= 1'b0;
			rd_dat <= '0;
		end else begin
			ack <= req;
			if (req) begin
				// Status byte: flag A in bit 0, flag B in bit 1
				if (!wb_req.we && !wb_req.adr)
					rd_dat <= {6'b0, flags.flag_b, flags.flag_a};
				else
					rd_dat <= '0;
			end
		end
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_dat;

	// Register number latch and write decode
	always_ff @(posedge clk_int) begin
		if (reset) begin
			reg_num <= '0;
			ta_hi   <= '0;
			ta_lo   <= '0;
			tb_val  <= '0;
			tctrl   <= '0;
			clr_a   <= 1'b0;
			clr_b   <= 1'b0;
			pcm     <= '0;
			pcm_en  <= 1'b0;
			for (int i = 0; i < `FM_NUM_CH; i++)
				ch_cfg[i] <= '0;
		end else begin
			// Flag clears last a single cycle
			clr_a <= 1'b0;
			clr_b <= 1'b0;

			if (wr_addr)
				reg_num <= wb_req.dat;

			if (wr_data) begin
				case (reg_num)
					`FM_REG_TA_HI:  ta_hi  <= wb_req.dat;
					`FM_REG_TA_LO:  ta_lo  <= wb_req.dat[1:0];
					`FM_REG_TB:     tb_val <= wb_req.dat;
					`FM_REG_TCTRL: begin
						tctrl <= wb_req.dat[3:0];
						clr_a <= wb_req.dat[4];
						clr_b <= wb_req.dat[5];
					end
					`FM_REG_PCM:    pcm    <= wb_req.dat;
					`FM_REG_PCM_EN: pcm_en <= wb_req.dat[7];
					default: ;
				endcase

				for (int i = 0; i < `FM_NUM_CH; i++) begin
					if (reg_num == 8'(`FM_REG_FNUM_LO + i))
						ch_cfg[i].fnum[7:0] <= wb_req.dat;
					if (reg_num == 8'(`FM_REG_FNUM_HI + i)) begin
						ch_cfg[i].block      <= wb_req.dat[5:3];
						ch_cfg[i].fnum[10:8] <= wb_req.dat[2:0];
					end
					if (reg_num == 8'(`FM_REG_PAN + i))
						ch_cfg[i].pan <= wb_req.dat[7:6];
				end
			end
		end
	end

	// Control register bits 3:0 are load A, load B, irq A, irq B
	assign timer_cfg.value_a  = {ta_hi, ta_lo};
	assign timer_cfg.value_b  = tb_val;
	assign timer_cfg.load_a   = tctrl[0];
	assign timer_cfg.load_b   = tctrl[1];
	assign timer_cfg.irq_en_a = tctrl[2];
	assign timer_cfg.irq_en_b = tctrl[3];
	assign timer_cfg.clr_a    = clr_a;
	assign timer_cfg.clr_b    = clr_b;

endmodule

//--- design/fm_timers.sv
`timescale 1ns/1ps
`include "fm_consts.svh"

module fm_timers (
	input  logic                 clk_int,
	input  logic                 reset,
	input  logic                 tick,
	input  fm_pkg::timer_cfg_t   timer_cfg,
	output fm_pkg::timer_flags_t flags,
	output logic                 irq_n
);

	fm_pkg::ta_value_t cnt_a;
	fm_pkg::tb_value_t cnt_b;
	logic [3:0]        pre_b;
	logic              load_a_q;
	logic              load_b_q;
	logic              start_a;
	logic              start_b;
	logic              ov_a;
	logic              step_b;
	logic              ov_b;

	// Counters restart when their load bit rises
	assign start_a = timer_cfg.load_a & ~load_a_q;
	assign start_b = timer_cfg.load_b & ~load_b_q;

	assign ov_a   = tick & timer_cfg.load_a & (cnt_a == '1);
	assign step_b = tick & timer_cfg.load_b & (pre_b == 4'(`FM_TB_PRESCALE - 1));
	assign ov_b   = step_b & (cnt_b == '1);

	always_ff @(posedge clk_int) begin
		if (reset) begin
			load_a_q <= 1'b0;
			load_b_q <= 1'b0;
			cnt_a    <= '0;
			cnt_b    <= '0;
			pre_b    <= '0;
		end else begin
			load_a_q <= timer_cfg.load_a;
			load_b_q <= timer_cfg.load_b;

			// Timer A, one step per tick
			if (start_a || ov_a)
				cnt_a <= timer_cfg.value_a;
			else if (tick && timer_cfg.load_a)
				cnt_a <= cnt_a + 1'b1;

			// Timer B behind the tick prescaler
			if (start_b) begin
				cnt_b <= timer_cfg.value_b;
				pre_b <= '0;
			end else if (tick && timer_cfg.load_b) begin
				if (step_b)
					pre_b <= '0;
				else
					pre_b <= pre_b + 1'b1;
				if (ov_b)
					cnt_b <= timer_cfg.value_b;
				else if (step_b)
					cnt_b <= cnt_b + 1'b1;
			end
		end
	end

	// Flags set on enabled overflow, cleared by the control write
	always_ff @(posedge clk_int) begin
		if (reset) begin
			flags <= '0;
		end else begin
			if (timer_cfg.clr_a)
				flags.flag_a <= 1'b0;
			else if (ov_a && timer_cfg.irq_en_a)
				flags.flag_a <= 1'b1;

			if (timer_cfg.clr_b)
				flags.flag_b <= 1'b0;
			else if (ov_b && timer_cfg.irq_en_b)
				flags.flag_b <= 1'b1;
		end
	end

	assign irq_n = ~(flags.flag_a | flags.flag_b);

endmodule

//--- design/fm_phase.sv
`timescale 1ns/1ps
`include "fm_consts.svh"

module fm_phase (
	input  logic                             clk_int,
	input  logic                             reset,
	input  fm_pkg::ch_cfg_t [`FM_NUM_CH-1:0] ch_cfg,
	output fm_pkg::phase_t                   phase_out,
	output fm_pkg::slot_e                    slot_out,
	output logic                             tick
);

	fm_pkg::slot_e   slot;
	fm_pkg::phase_t  phase [`FM_NUM_CH];
	logic [1:0]      ch_idx;
	fm_pkg::ch_cfg_t cfg_sel;
	fm_pkg::phase_t  inc;
	fm_pkg::phase_t  sum;

	// Channel served in this slot, don't care during SLOT_OUT
	assign ch_idx  = (slot == fm_pkg::SLOT_OUT) ? 2'd0 : slot;
	assign cfg_sel = ch_cfg[ch_idx];

	// Shared adder
	assign inc = (fm_pkg::phase_t'(cfg_sel.fnum) << cfg_sel.block) >> 1;
	assign sum = phase[ch_idx] + inc;

	// Slot sequencer
	always_ff @(posedge clk_int) begin
		if (reset) begin
			slot <= fm_pkg::SLOT_CH0;
		end else begin
			case (slot)
				fm_pkg::SLOT_CH0: slot <= fm_pkg::SLOT_CH1;
				fm_pkg::SLOT_CH1: slot <= fm_pkg::SLOT_CH2;
				fm_pkg::SLOT_CH2: slot <= fm_pkg::SLOT_OUT;
				default:          slot <= fm_pkg::SLOT_CH0;
			endcase
		end
	end

	always_ff @(posedge clk_int) begin
		if (reset) begin
			for (int i = 0; i < `FM_NUM_CH; i++)
				phase[i] <= '0;
			phase_out <= '0;
			// Tag idle after reset so the mixer adds no stale channel
			slot_out  <= fm_pkg::SLOT_OUT;
		end else begin
			slot_out <= slot;
			if (slot != fm_pkg::SLOT_OUT) begin
				phase[ch_idx] <= sum;
				phase_out     <= sum;
			end
		end
	end

	assign tick = (slot == fm_pkg::SLOT_OUT);

endmodule

//--- design/fm_mixer.sv
`timescale 1ns/1ps
`include "fm_consts.svh"

module fm_mixer (
	input  logic                             clk_int,
	input  logic                             reset,
	input  fm_pkg::phase_t                   phase_in,
	input  fm_pkg::slot_e                    slot_in,
	input  fm_pkg::ch_cfg_t [`FM_NUM_CH-1:0] ch_cfg,
	input  fm_pkg::pcm_t                     pcm,
	input  logic                             pcm_en,
	output fm_pkg::sample_t                  left,
	output fm_pkg::sample_t                  right,
	output logic                             sample
);

	logic [1:0]           ch_idx;
	fm_pkg::pan_t         pan_sel;
	logic [`FM_OUT_W-1:0] saw;
	logic signed [7:0]    pcm_s;
	fm_pkg::sample_t      pcm_lvl;
	fm_pkg::sample_t      level;
	fm_pkg::sample_t      acc_l;
	fm_pkg::sample_t      acc_r;

	assign ch_idx  = (slot_in == fm_pkg::SLOT_OUT) ? 2'd0 : slot_in;
	assign pan_sel = ch_cfg[ch_idx].pan;

	// Sawtooth from the top phase bits, centred on zero
	assign saw = phase_in[`FM_PHASE_W-1 -: `FM_OUT_W] - `FM_OUT_W'(2048);

	// PCM is offset binary, scaled up to the output range
	assign pcm_s   = pcm - 8'd128;
	assign pcm_lvl = fm_pkg::sample_t'(pcm_s) <<< 4;

	always_comb begin
		if (slot_in == fm_pkg::SLOT_CH2 && pcm_en)
			level = pcm_lvl;
		else
			level = fm_pkg::sample_t'(saw);
	end

	always_ff @(posedge clk_int) begin
		if (reset) begin
			acc_l  <= '0;
			acc_r  <= '0;
			left   <= '0;
			right  <= '0;
			sample <= 1'b0;
		end else if (slot_in == fm_pkg::SLOT_OUT) begin
			// End of round, publish and start over
			left   <= acc_l;
			right  <= acc_r;
			acc_l  <= '0;
			acc_r  <= '0;
			sample <= 1'b1;
		end else begin
			sample <= 1'b0;
			// Sums wrap in the output width
			if (pan_sel[1])
				acc_l <= acc_l + level;
			if (pan_sel[0])
				acc_r <= acc_r + level;
		end
	end

endmodule

//--- design/fm_top.sv
`timescale 1ns/1ps
`include "fm_consts.svh"

module fm_top (
	input  logic            clk_int,
	input  logic            reset,
	input  fm_pkg::wb_req_t wb_req,
	output fm_pkg::wb_rsp_t wb_rsp,
	output fm_pkg::sample_t left,
	output fm_pkg::sample_t right,
	output logic            sample,
	output logic            irq_n
);

	fm_pkg::timer_cfg_t               timer_cfg;
	fm_pkg::timer_flags_t             flags;
	fm_pkg::ch_cfg_t [`FM_NUM_CH-1:0] ch_cfg;
	fm_pkg::pcm_t                     pcm;
	logic                             pcm_en;
	fm_pkg::phase_t                   phase;
	fm_pkg::slot_e                    slot;
	logic                             tick;

	// Host registers
	fm_regs u_regs (
		.clk_int   (clk_int),
		.reset     (reset),
		.wb_req    (wb_req),
		.flags     (flags),
		.wb_rsp    (wb_rsp),
		.timer_cfg (timer_cfg),
		.ch_cfg    (ch_cfg),
		.pcm       (pcm),
		.pcm_en    (pcm_en)
	);

	// Timers count output rounds
	fm_timers u_timers (
		.clk_int   (clk_int),
		.reset     (reset),
		.tick      (tick),
		.timer_cfg (timer_cfg),
		.flags     (flags),
		.irq_n     (irq_n)
	);

	fm_phase u_phase (
		.clk_int   (clk_int),
		.reset     (reset),
		.ch_cfg    (ch_cfg),
		.phase_out (phase),
		.slot_out  (slot),
		.tick      (tick)
	);

	fm_mixer u_mixer (
		.clk_int  (clk_int),
		.reset    (reset),
		.phase_in (phase),
		.slot_in  (slot),
		.ch_cfg   (ch_cfg),
		.pcm      (pcm),
		.pcm_en   (pcm_en),
		.left     (left),
		.right    (right),
		.sample   (sample)
	);

endmodule

//--- verification/fm_tb.sv
`timescale 1ns/1ps
`include "fm_consts.svh"

module fm_tb;

	// Longest timer B period in clock cycles, plus room for the rest of the table
	localparam int MAX_TIMER_CYCLES = 4 * `FM_TB_PRESCALE * 256;
	localparam int TABLE_MARGIN     = 3616;
	localparam int TIMEOUT_CYCLES   = MAX_TIMER_CYCLES + TABLE_MARGIN;
	localparam int NUM_STIM         = 16;

	typedef enum logic [1:0] {
		KIND_CH,
		KIND_PCM,
		KIND_TIMER
	} kind_e;

	// For timer entries ch picks timer A (0) or timer B (1)
	typedef struct packed {
		kind_e             kind;
		logic [1:0]        ch;
		fm_pkg::fnum_t     fnum;
		fm_pkg::block_t    block;
		fm_pkg::pan_t      pan;
		fm_pkg::pcm_t      pcm;
		fm_pkg::ta_value_t tval;
		logic              rnd;
	} stim_t;

	logic            clk_int;
	logic            reset;
	fm_pkg::wb_req_t wb_req;
	fm_pkg::wb_rsp_t wb_rsp;
	fm_pkg::sample_t left;
	fm_pkg::sample_t right;
	logic            sample;
	logic            irq_n;
	int              cycles = 0;

	// Channel settings as last written
	fm_pkg::pan_t m_pan   [`FM_NUM_CH];
	int           m_inc   [`FM_NUM_CH];
	logic         m_still [`FM_NUM_CH];

	// Pan tests run first, while every phase is still zero
	stim_t stim [NUM_STIM] = '{
		'{KIND_CH,    2'd0, 11'h000, 3'd0, 2'b10, 8'h00, 10'h000, 1'b0},
		'{KIND_CH,    2'd1, 11'h000, 3'd0, 2'b01, 8'h00, 10'h000, 1'b0},
		'{KIND_CH,    2'd0, 11'h000, 3'd0, 2'b00, 8'h00, 10'h000, 1'b0},
		'{KIND_CH,    2'd1, 11'h000, 3'd0, 2'b00, 8'h00, 10'h000, 1'b0},
		'{KIND_CH,    2'd0, 11'h200, 3'd1, 2'b11, 8'h00, 10'h000, 1'b0},
		'{KIND_CH,    2'd0, 11'h400, 3'd4, 2'b11, 8'h00, 10'h000, 1'b0},
		'{KIND_CH,    2'd1, 11'h100, 3'd2, 2'b00, 8'h00, 10'h000, 1'b1},
		'{KIND_CH,    2'd0, 11'h000, 3'd0, 2'b00, 8'h00, 10'h000, 1'b0},
		'{KIND_CH,    2'd1, 11'h000, 3'd0, 2'b00, 8'h00, 10'h000, 1'b0},
		'{KIND_CH,    2'd2, 11'h000, 3'd0, 2'b11, 8'h00, 10'h000, 1'b0},
		'{KIND_PCM,   2'd2, 11'h000, 3'd0, 2'b11, 8'h00, 10'h000, 1'b0},
		'{KIND_PCM,   2'd2, 11'h000, 3'd0, 2'b11, 8'h00, 10'h000, 1'b1},
		'{KIND_PCM,   2'd2, 11'h000, 3'd0, 2'b11, 8'h00, 10'h000, 1'b1},
		'{KIND_PCM,   2'd2, 11'h000, 3'd0, 2'b11, 8'hFF, 10'h000, 1'b0},
		'{KIND_TIMER, 2'd0, 11'h000, 3'd0, 2'b00, 8'h00, 10'h3C0, 1'b0},
		'{KIND_TIMER, 2'd1, 11'h000, 3'd0, 2'b00, 8'h00, 10'h0F0, 1'b0}
	};

	fm_top u_fm_top (
		.clk_int (clk_int),
		.reset   (reset),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.left    (left),
		.right   (right),
		.sample  (sample),
		.irq_n   (irq_n)
	);

	initial begin
		clk_int = 1'b0;
		forever #10 clk_int = ~clk_int;
	end

	always @(posedge clk_int) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d clock cycles", TIMEOUT_CYCLES);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	task automatic check_sample(input string name, input fm_pkg::sample_t got,
		input fm_pkg::sample_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "sample check");
		end
	endtask

	task automatic check_flags(input fm_pkg::timer_flags_t got, input fm_pkg::timer_flags_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: flags got a=%b b=%b expected a=%b b=%b",
				$time, got.flag_a, got.flag_b, exp.flag_a, exp.flag_b);
			$display("tests failed");
			$fatal(1, "flag check");
		end
	endtask

	task automatic check_count(input string name, input integer got, input integer exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "count check");
		end
	endtask

	// Returns exp when got lies inside the window, else got unchanged
	function automatic int window_match(input int got, input int exp, input int tol);
		if (got >= exp - tol && got <= exp + tol)
			return exp;
		return got;
	endfunction

	task automatic wb_write(input logic adr, input logic [7:0] dat);
		@(posedge clk_int);
		#2;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b1;
		wb_req.adr = adr;
		wb_req.dat = dat;
		do @(negedge clk_int); while (!wb_rsp.ack);
		@(posedge clk_int);
		#2;
		wb_req = '0;
	endtask

	task automatic wb_read(input logic adr, output logic [7:0] dat);
		@(posedge clk_int);
		#2;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b0;
		wb_req.adr = adr;
		do @(negedge clk_int); while (!wb_rsp.ack);
		dat = wb_rsp.dat;
		@(posedge clk_int);
		#2;
		wb_req = '0;
	endtask

	task automatic reg_write(input logic [7:0] num, input logic [7:0] dat);
		wb_write(1'b0, num);
		wb_write(1'b1, dat);
	endtask

	task automatic next_sample();
		do @(negedge clk_int); while (!sample);
	endtask

	// side 1 is left, side 0 is right
	function automatic fm_pkg::sample_t side_step(input int side);
		int sum;
		sum = 0;
		for (int c = 0; c < `FM_NUM_CH; c++)
			if (m_pan[c][side])
				sum += m_inc[c] / 256;
		return fm_pkg::sample_t'(sum);
	endfunction

	function automatic logic side_still(input int side);
		logic still;
		still = 1'b1;
		for (int c = 0; c < `FM_NUM_CH; c++)
			if (m_pan[c][side] && !m_still[c])
				still = 1'b0;
		return still;
	endfunction

	// Phase zero gives -2048 per channel
	function automatic fm_pkg::sample_t side_level(input int side);
		int sum;
		sum = 0;
		for (int c = 0; c < `FM_NUM_CH; c++)
			if (m_pan[c][side])
				sum -= 2048;
		return fm_pkg::sample_t'(sum);
	endfunction

	task automatic check_channels();
		fm_pkg::sample_t prev_l;
		fm_pkg::sample_t prev_r;
		// First sample may hold a partly updated round
		next_sample();
		next_sample();
		prev_l = left;
		prev_r = right;
		repeat (4) begin
			next_sample();
			check_sample("left step", fm_pkg::sample_t'(left - prev_l), side_step(1));
			check_sample("right step", fm_pkg::sample_t'(right - prev_r), side_step(0));
			if (side_still(1))
				check_sample("left", left, side_level(1));
			if (side_still(0))
				check_sample("right", right, side_level(0));
			prev_l = left;
			prev_r = right;
		end
	endtask

	task automatic apply_channel(input stim_t s);
		if (s.rnd)
			s.pan = 2'($urandom % 4);
		reg_write(8'(`FM_REG_FNUM_LO + s.ch), s.fnum[7:0]);
		reg_write(8'(`FM_REG_FNUM_HI + s.ch), {2'b00, s.block, s.fnum[10:8]});
		reg_write(8'(`FM_REG_PAN + s.ch), {s.pan, 6'b0});
		m_pan[s.ch] = s.pan;
		m_inc[s.ch] = (int'(s.fnum) << s.block) / 2;
		if (m_inc[s.ch] != 0)
			m_still[s.ch] = 1'b0;
		check_channels();
	endtask

	task automatic apply_pcm(input stim_t s);
		fm_pkg::sample_t level;
		if (s.rnd)
			s.pcm = 8'($urandom % 256);
		level = fm_pkg::sample_t'((int'(s.pcm) - 128) * 16);
		reg_write(`FM_REG_PCM, s.pcm);
		reg_write(`FM_REG_PCM_EN, 8'h80);
		next_sample();
		next_sample();
		repeat (3) begin
			next_sample();
			check_sample("left pcm", left, m_pan[2][1] ? level : fm_pkg::sample_t'(0));
			check_sample("right pcm", right, m_pan[2][0] ? level : fm_pkg::sample_t'(0));
		end
	endtask

	task automatic apply_timer(input stim_t s);
		int                   n;
		int                   expect_n;
		int                   tol;
		logic [7:0]           dat;
		fm_pkg::timer_flags_t got;
		fm_pkg::timer_flags_t want;
		if (s.ch == 2'd0) begin
			reg_write(`FM_REG_TA_HI, s.tval[9:2]);
			reg_write(`FM_REG_TA_LO, {6'b0, s.tval[1:0]});
			reg_write(`FM_REG_TCTRL, 8'h05);
			expect_n = 1024 - int'(s.tval);
			tol = 1;
		end else begin
			reg_write(`FM_REG_TB, s.tval[7:0]);
			reg_write(`FM_REG_TCTRL, 8'h0A);
			expect_n = `FM_TB_PRESCALE * (256 - int'(s.tval[7:0]));
			tol = `FM_TB_PRESCALE;
		end
		// Count output samples until the interrupt fires
		n = 0;
		do begin
			@(negedge clk_int);
			if (sample)
				n++;
		end while (irq_n);
		check_count("timer period", window_match(n, expect_n, tol), expect_n);
		wb_read(1'b0, dat);
		got.flag_a  = dat[0];
		got.flag_b  = dat[1];
		want.flag_a = (s.ch == 2'd0);
		want.flag_b = (s.ch != 2'd0);
		check_flags(got, want);
		// Data port reads zero even while a flag is set
		wb_read(1'b1, dat);
		check_count("data port read", dat, 0);
		reg_write(`FM_REG_TCTRL, (s.ch == 2'd0) ? 8'h10 : 8'h20);
		@(negedge clk_int);
		check_count("irq_n after clear", irq_n, 1);
	endtask

	initial begin
		logic [7:0]           dat;
		fm_pkg::timer_flags_t got;
		void'($urandom(16));
		reset  = 1'b1;
		wb_req = '0;
		for (int c = 0; c < `FM_NUM_CH; c++) begin
			m_pan[c]   = '0;
			m_inc[c]   = 0;
			m_still[c] = 1'b1;
		end
		repeat (4) @(posedge clk_int);
		#2;
		reset = 1'b0;

		// Idle chip, nothing panned
		next_sample();
		next_sample();
		check_sample("left", left, '0);
		check_sample("right", right, '0);
		check_count("irq_n", irq_n, 1);
		wb_read(1'b0, dat);
		got.flag_a = dat[0];
		got.flag_b = dat[1];
		check_flags(got, '0);
		check_count("status upper bits", dat[7:2], 0);

		for (int i = 0; i < NUM_STIM; i++) begin
			case (stim[i].kind)
				KIND_CH:  apply_channel(stim[i]);
				KIND_PCM: apply_pcm(stim[i]);
				default:  apply_timer(stim[i]);
			endcase
		end

		$display("all tests passed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+design
design/fm_pkg.sv
design/fm_regs.sv
design/fm_timers.sv
design/fm_phase.sv
design/fm_mixer.sv
design/fm_top.sv
verification/fm_tb.sv

//--- Bender.yml
package:
  name: fm_synth

sources:
  - include_dirs:
      - design
    files:
      - design/fm_pkg.sv
      - design/fm_regs.sv
      - design/fm_timers.sv
      - design/fm_phase.sv
      - design/fm_mixer.sv
      - design/fm_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/fm_tb.sv
